/* qupls4Cfg_cfg.svh */
// Configuration macros: datapath width, micro-op field positions and trap vector addresses
`ifndef QUPLS4CFG_CFG_SVH
`define QUPLS4CFG_CFG_SVH

// ========================================
// Datapath
// ========================================

// Width of operands, link data and program counters
`define QW_DATA 64

// ========================================
// Micro-op fields
// ========================================

// Opcode sits in the low seven bits of the micro-op word
`define QW_OPC_LSB 0
`define QW_OPC_MSB 6
// Link register number, bits 7 to 11
`define QW_RD_LSB 7
// Branch condition, bits 12 to 14
`define QW_COND_LSB 12
// Displacement is signed and counted in four-byte units, bits 20 to 31
`define QW_DISP_LSB 20
`define QW_DISP_BITS 12

// Fixed entry points for a break and for a failed bound check
`define QW_BRK_VECTOR 64'hFFFF_FFFF_FFFC_0000
`define QW_CHK_VECTOR 64'hFFFF_FFFF_FFFC_0040

`endif

/* Qupls4Pkg.sv */
// Package: vector typedefs, opcode constants, condition codes, compare widths and fault codes
`include "qupls4Cfg_cfg.svh"

package Qupls4Pkg;

	// ========================================
	// Vector types
	// ========================================

	// One micro-op word as it leaves the rename stage
	typedef logic [31:0] instr_t;
	typedef logic [6:0] opcode_t;
	// Operand and link data
	typedef logic [`QW_DATA-1:0] word_t;
	// Program counters and branch targets
	typedef logic [`QW_DATA-1:0] addr_t;
	typedef logic [4:0] regNum_t;
	typedef logic [2:0] cond_t;
	// Selects the compare width of a conditional branch
	typedef logic [1:0] cmpWidth_t;
	typedef logic [1:0] fault_t;
	// Wrapping event counters
	typedef logic [15:0] count_t;

	// ========================================
	// Opcodes
	// ========================================

	localparam opcode_t OP_BRK = 7'h00;
	localparam opcode_t OP_ADD = 7'h04;
	localparam opcode_t OP_CHK = 7'h1C;
	// Signed conditional branches, one opcode per compare width
	localparam opcode_t OP_BCC8 = 7'h28;
	localparam opcode_t OP_BCC16 = 7'h29;
	localparam opcode_t OP_BCC32 = 7'h2A;
	localparam opcode_t OP_BCC64 = 7'h2B;
	// Unsigned conditional branches
	localparam opcode_t OP_BCCU8 = 7'h2C;
	localparam opcode_t OP_BCCU16 = 7'h2D;
	localparam opcode_t OP_BCCU32 = 7'h2E;
	localparam opcode_t OP_BCCU64 = 7'h2F;
	// Subroutine calls and the jump that keeps no return address
	localparam opcode_t OP_BSR = 7'h30;
	localparam opcode_t OP_JSR = 7'h31;
	localparam opcode_t OP_JSRN = 7'h32;
	localparam opcode_t OP_NOP = 7'h7F;

	// ========================================
	// Branch conditions
	// ========================================

	localparam cond_t COND_EQ = 3'd0;
	localparam cond_t COND_NE = 3'd1;
	localparam cond_t COND_LT = 3'd2;
	localparam cond_t COND_GE = 3'd3;
	localparam cond_t COND_LE = 3'd4;
	localparam cond_t COND_GT = 3'd5;

	// Compare widths of 8, 16, 32 and 64 bits
	localparam cmpWidth_t CMP_W8 = 2'd0;
	localparam cmpWidth_t CMP_W16 = 2'd1;
	localparam cmpWidth_t CMP_W32 = 2'd2;
	localparam cmpWidth_t CMP_W64 = 2'd3;

	// Fault reported with a redirect
	localparam fault_t FAULT_NONE = 2'd0;
	localparam fault_t FAULT_BRK = 2'd1;
	localparam fault_t FAULT_CHK = 2'd2;

endpackage

/* flowIfc.sv */
// Interfaces: decodeExecIfc and execCommitIfc with their stage modports

// Decoded micro-op handed from the decode register to execute
interface decodeExecIfc;

	import Qupls4Pkg::*;

	// Control bits are already qualified by valid
	logic valid;
	logic isFlowCtrl;
	logic isBranch;
	logic isCall;
	logic isBreak;
	logic isCheck;
	logic saveLink;
	// Compare controls for conditional branches
	cond_t cond;
	cmpWidth_t cmpWidth;
	logic isSigned;
	// Operands; srcA carries the pc for a BSR so one adder serves every call
	addr_t pc;
	word_t srcA;
	word_t srcB;
	// Byte displacement, sign-extended and scaled
	word_t disp;
	regNum_t rd;

	modport decode (
		output valid, isFlowCtrl, isBranch, isCall, isBreak, isCheck, saveLink,
		output cond, cmpWidth, isSigned, pc, srcA, srcB, disp, rd
	);

	modport execute (
		input valid, isFlowCtrl, isBranch, isCall, isBreak, isCheck, saveLink,
		input cond, cmpWidth, isSigned, pc, srcA, srcB, disp, rd
	);

endinterface

// Resolved flow-control result handed from execute to commit
interface execCommitIfc;

	import Qupls4Pkg::*;

	logic valid;
	logic isFlowCtrl;
	logic isBranch;
	// High when control leaves the sequential path
	logic taken;
	addr_t target;
	logic linkWe;
	regNum_t linkReg;
	word_t linkData;
	fault_t fault;

	modport execute (
		output valid, isFlowCtrl, isBranch, taken, target, linkWe, linkReg, linkData, fault
	);

	modport commit (
		input valid, isFlowCtrl, isBranch, taken, target, linkWe, linkReg, linkData, fault
	);

endinterface

/* microOpDecode.sv */
// Decode stage: flow-control classification, field extraction and the decode register
`include "qupls4Cfg_cfg.svh"

module microOpDecode
(
	input logic clk,
	input logic arstN,
	input logic inValid,
	input Qupls4Pkg::instr_t instr,
	input Qupls4Pkg::addr_t pc,
	input Qupls4Pkg::word_t srcA,
	input Qupls4Pkg::word_t srcB,
	decodeExecIfc.decode dx
);

	import Qupls4Pkg::*;

	// ========================================
	// Opcode classification
	// ========================================

	// True for every opcode that may move control off the sequential path
	function automatic logic fnIsFlowCtrl(input opcode_t op);
		case (op)
		OP_BRK,
		OP_CHK:
			return 1'b1;
		OP_BCC8, OP_BCC16, OP_BCC32, OP_BCC64,
		OP_BCCU8, OP_BCCU16, OP_BCCU32, OP_BCCU64:
			return 1'b1;
		OP_BSR, OP_JSR, OP_JSRN:
			return 1'b1;
		default:
			return 1'b0;
		endcase
	endfunction

	// Class flags, packed as {branch, call, break, check}
	function automatic logic [3:0] fnClassFlags(input opcode_t op);
		case (op)
		OP_BCC8, OP_BCC16, OP_BCC32, OP_BCC64,
		OP_BCCU8, OP_BCCU16, OP_BCCU32, OP_BCCU64:
			return 4'b1000;
		OP_BSR, OP_JSR, OP_JSRN:
			return 4'b0100;
		OP_BRK:
			return 4'b0010;
		OP_CHK:
			return 4'b0001;
		default:
			return 4'b0000;
		endcase
	endfunction

	// Compare width follows the branch variant; anything else compares full width
	function automatic cmpWidth_t fnCmpWidth(input opcode_t op);
		case (op)
		OP_BCC8, OP_BCCU8:
			return CMP_W8;
		OP_BCC16, OP_BCCU16:
			return CMP_W16;
		OP_BCC32, OP_BCCU32:
			return CMP_W32;
		default:
			return CMP_W64;
		endcase
	endfunction

	opcode_t opc;
	logic fcNext;
	logic [3:0] classNext;
	logic saveLinkNext;
	logic isSignedNext;
	word_t baseNext;
	word_t dispNext;

	assign opc = instr[`QW_OPC_MSB:`QW_OPC_LSB];
	assign fcNext = fnIsFlowCtrl(opc);
	assign classNext = fnClassFlags(opc);
	// Only BSR and JSR keep a return address, JSRN does not
	assign saveLinkNext = (opc == OP_BSR) || (opc == OP_JSR);
	assign isSignedNext = opc inside {OP_BCC8, OP_BCC16, OP_BCC32, OP_BCC64};
	// A BSR is relative to its own pc, so the pc takes the place of srcA
	assign baseNext = (opc == OP_BSR) ? word_t'(pc) : srcA;
	// Sign-extend the displacement and scale it from words to bytes
	assign dispNext = {{(`QW_DATA - `QW_DISP_BITS - 2){instr[`QW_DISP_LSB + `QW_DISP_BITS - 1]}},
		instr[`QW_DISP_LSB +: `QW_DISP_BITS], 2'b00};

	// ========================================
	// Decode register
	// ========================================

	// Control bits carry valid with them so later stages need no extra gating
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			dx.valid <= 1'b0;
			dx.isFlowCtrl <= 1'b0;
			dx.isBranch <= 1'b0;
			dx.isCall <= 1'b0;
			dx.isBreak <= 1'b0;
			dx.isCheck <= 1'b0;
			dx.saveLink <= 1'b0;
		end
		else
		begin
			dx.valid <= inValid;
			dx.isFlowCtrl <= inValid & fcNext;
			dx.isBranch <= inValid & classNext[3];
			dx.isCall <= inValid & classNext[2];
			dx.isBreak <= inValid & classNext[1];
			dx.isCheck <= inValid & classNext[0];
			dx.saveLink <= inValid & saveLinkNext;
		end
	end

	// Payload fields
	always_ff @(posedge clk)
	begin
		dx.cond <= instr[`QW_COND_LSB +: $bits(cond_t)];
		dx.cmpWidth <= fnCmpWidth(opc);
		dx.isSigned <= isSignedNext;
		dx.pc <= pc;
		dx.srcA <= baseNext;
		dx.srcB <= srcB;
		dx.disp <= dispNext;
		dx.rd <= instr[`QW_RD_LSB +: $bits(regNum_t)];
	end

	// The strobe must be clean for the whole pipeline to count micro-ops
	assert property (@(posedge clk) disable iff (!arstN) !$isunknown(inValid));

endmodule

/* branchExecute.sv */
// Execute stage: branch condition evaluation, bound check, target and link generation
`include "qupls4Cfg_cfg.svh"

module branchExecute
(
	input logic clk,
	input logic arstN,
	decodeExecIfc.execute dx,
	execCommitIfc.execute xc
);

	import Qupls4Pkg::*;

	// ========================================
	// Compare helpers
	// ========================================

	// Truncate to the compare width, then sign- or zero-extend back to full width
	function automatic word_t fnExtend(input word_t v, input cmpWidth_t w, input logic sgn);
		case (w)
		CMP_W8:
			return {{(`QW_DATA - 8){sgn & v[7]}}, v[7:0]};
		CMP_W16:
			return {{(`QW_DATA - 16){sgn & v[15]}}, v[15:0]};
		CMP_W32:
			return {{(`QW_DATA - 32){sgn & v[31]}}, v[31:0]};
		default:
			return v;
		endcase
	endfunction

	// Six conditions built from equal and less-than
	function automatic logic fnCondTrue(input cond_t c, input logic eq, input logic lt);
		case (c)
		COND_EQ:
			return eq;
		COND_NE:
			return !eq;
		COND_LT:
			return lt;
		COND_GE:
			return !lt;
		COND_LE:
			return lt || eq;
		COND_GT:
			return !(lt || eq);
		default:
			return 1'b0;
		endcase
	endfunction

	word_t aExt;
	word_t bExt;
	logic cmpEq;
	logic cmpLt;
	logic condTrue;
	logic chkPass;
	logic takenNext;
	addr_t targetNext;
	fault_t faultNext;

	assign aExt = fnExtend(dx.srcA, dx.cmpWidth, dx.isSigned);
	assign bExt = fnExtend(dx.srcB, dx.cmpWidth, dx.isSigned);
	assign cmpEq = (aExt == bExt);
	// After extension a full-width compare gives the narrow result
	assign cmpLt = dx.isSigned ? ($signed(aExt) < $signed(bExt)) : (aExt < bExt);
	assign condTrue = fnCondTrue(dx.cond, cmpEq, cmpLt);
	// CHK passes when the index lies below the bound, unsigned
	assign chkPass = (dx.srcA < dx.srcB);

	// Class flags are already valid-qualified by decode
	assign takenNext = dx.isBreak | dx.isCall | (dx.isBranch & condTrue)
		| (dx.isCheck & ~chkPass);

	// ========================================
	// Target and fault selection
	// ========================================

	always_comb
	begin
		if (dx.isBreak)
			targetNext = `QW_BRK_VECTOR;
		else if (dx.isCheck)
			targetNext = `QW_CHK_VECTOR;
		// srcA holds the pc for BSR and the register base for JSR and JSRN
		else if (dx.isCall)
			targetNext = addr_t'(dx.srcA) + addr_t'(dx.disp);
		else
			targetNext = dx.pc + addr_t'(dx.disp);
	end

	always_comb
	begin
		faultNext = FAULT_NONE;
		if (dx.isBreak)
			faultNext = FAULT_BRK;
		else if (dx.isCheck && !chkPass)
			faultNext = FAULT_CHK;
	end

	// Execute register, control part
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			xc.valid <= 1'b0;
			xc.isFlowCtrl <= 1'b0;
			xc.isBranch <= 1'b0;
			xc.taken <= 1'b0;
			xc.linkWe <= 1'b0;
			xc.fault <= FAULT_NONE;
		end
		else
		begin
			xc.valid <= dx.valid;
			xc.isFlowCtrl <= dx.isFlowCtrl;
			xc.isBranch <= dx.isBranch;
			xc.taken <= takenNext;
			xc.linkWe <= dx.saveLink;
			xc.fault <= faultNext;
		end
	end

	// Payload part; the return address is the next sequential micro-op
	always_ff @(posedge clk)
	begin
		xc.target <= targetNext;
		xc.linkReg <= dx.rd;
		xc.linkData <= word_t'(dx.pc) + word_t'(4);
	end

	// A redirect is only ever raised for an opcode that decode marked as flow control
	assert property (@(posedge clk) disable iff (!arstN) xc.taken |-> xc.isFlowCtrl);

endmodule

/* flowCommit.sv */
// Commit stage: output register for the redirect and link ports, branch and taken counters

module flowCommit
(
	input logic clk,
	input logic arstN,
	execCommitIfc.commit xc,
	output logic outValid,
	output logic outFlowCtrl,
	output logic redirect,
	output logic linkWe,
	output Qupls4Pkg::addr_t redirectPc,
	output Qupls4Pkg::regNum_t linkReg,
	output Qupls4Pkg::word_t linkData,
	output Qupls4Pkg::fault_t fault,
	output Qupls4Pkg::count_t branchCount,
	output Qupls4Pkg::count_t takenCount
);

	import Qupls4Pkg::*;

	// A conditional branch reaches commit this cycle
	logic branchHit;
	// Any redirect reaches commit this cycle
	logic takenHit;

	assign branchHit = xc.valid & xc.isBranch;
	assign takenHit = xc.valid & xc.taken;

	// ========================================
	// Port register
	// ========================================

	// The flow-control flag, the redirect and the fault code are qualified by valid once more here
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			outValid <= 1'b0;
			outFlowCtrl <= 1'b0;
			redirect <= 1'b0;
			linkWe <= 1'b0;
			fault <= FAULT_NONE;
		end
		else
		begin
			outValid <= xc.valid;
			outFlowCtrl <= xc.valid & xc.isFlowCtrl;
			redirect <= takenHit;
			linkWe <= xc.linkWe;
			fault <= xc.valid ? xc.fault : FAULT_NONE;
		end
	end

	// Target and link payload only mean something alongside their strobes
	always_ff @(posedge clk)
	begin
		redirectPc <= xc.target;
		linkReg <= xc.linkReg;
		linkData <= xc.linkData;
	end

	// Event counters wrap at the top of count_t
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			branchCount <= '0;
			takenCount <= '0;
		end
		else
		begin
			if (branchHit)
				branchCount <= branchCount + count_t'(1);
			if (takenHit)
				takenCount <= takenCount + count_t'(1);
		end
	end

	// A link write never leaves the unit without its result strobe
	assert property (@(posedge clk) disable iff (!arstN) linkWe |-> outValid);

endmodule

/* flowCtrlUnit.sv */
// Top level of the flow-control unit: decode, execute and commit joined by stage interfaces

module flowCtrlUnit
(
	input logic clk,
	input logic arstN,
	// Micro-op from rename, one strobe per micro-op
	input logic inValid,
	input Qupls4Pkg::instr_t instr,
	input Qupls4Pkg::addr_t pc,
	input Qupls4Pkg::word_t srcA,
	input Qupls4Pkg::word_t srcB,
	// Result three cycles later
	output logic outValid,
	output logic outFlowCtrl,
	output logic redirect,
	output logic linkWe,
	output Qupls4Pkg::addr_t redirectPc,
	output Qupls4Pkg::regNum_t linkReg,
	output Qupls4Pkg::word_t linkData,
	output Qupls4Pkg::fault_t fault,
	output Qupls4Pkg::count_t branchCount,
	output Qupls4Pkg::count_t takenCount
);

	// Stage-to-stage buses
	decodeExecIfc dxIfc ();
	execCommitIfc xcIfc ();

	// First stage registers the classified micro-op
	microOpDecode microOpDecode_inst (
		.clk(clk),
		.arstN(arstN),
		.inValid(inValid),
		.instr(instr),
		.pc(pc),
		.srcA(srcA),
		.srcB(srcB),
		.dx(dxIfc.decode)
	);

	// Second stage resolves the branch and forms target, link and fault
	branchExecute branchExecute_inst (
		.clk(clk),
		.arstN(arstN),
		.dx(dxIfc.execute),
		.xc(xcIfc.execute)
	);

	// Third stage drives the ports and counts
	flowCommit flowCommit_inst (
		.clk(clk),
		.arstN(arstN),
		.xc(xcIfc.commit),
		.outValid(outValid),
		.outFlowCtrl(outFlowCtrl),
		.redirect(redirect),
		.linkWe(linkWe),
		.redirectPc(redirectPc),
		.linkReg(linkReg),
		.linkData(linkData),
		.fault(fault),
		.branchCount(branchCount),
		.takenCount(takenCount)
	);

endmodule

/* flowCtrlUnitTb.sv */
// Testbench for flowCtrlUnit: clock, reset, xorshift, reference model, directed tests, watchdog
`include "qupls4Cfg_cfg.svh"

module flowCtrlUnitTb;

	import Qupls4Pkg::*;

	// Micro-ops sent by the five tests, in the order they run
	localparam int NUM_OPS = 15 + 192 + 24 + 16 + 50;
	localparam int WATCHDOG_CYCLES = NUM_OPS + 50;

	// Expected result of one micro-op, queued when it is sent
	typedef struct packed {
		logic flowCtrl;
		logic isBranch;
		logic redirect;
		addr_t target;
		logic linkWe;
		regNum_t linkReg;
		word_t linkData;
		fault_t fault;
		int sendEdge;
	} expect_t;

	logic clk;
	logic arstN;
	logic inValid;
	instr_t instr;
	addr_t pc;
	word_t srcA;
	word_t srcB;
	logic outValid;
	logic outFlowCtrl;
	logic redirect;
	logic linkWe;
	addr_t redirectPc;
	regNum_t linkReg;
	word_t linkData;
	fault_t fault;
	count_t branchCount;
	count_t takenCount;

	expect_t expQ[$];
	expect_t cur;
	int cycleCnt = 0;
	int errCount = 0;
	int checkCount = 0;
	logic [63:0] rngState = 64'd55;
	count_t modelBranches = '0;
	count_t modelTaken = '0;
	opcode_t allOps [15] = '{OP_BRK, OP_CHK, OP_BCC8, OP_BCC16, OP_BCC32, OP_BCC64, OP_BCCU8,
		OP_BCCU16, OP_BCCU32, OP_BCCU64, OP_BSR, OP_JSR, OP_JSRN, OP_ADD, OP_NOP};
	// Signed variants first, then unsigned, each from 8 to 64 bits
	opcode_t bccOps [8] = '{OP_BCC8, OP_BCC16, OP_BCC32, OP_BCC64,
		OP_BCCU8, OP_BCCU16, OP_BCCU32, OP_BCCU64};

	flowCtrlUnit flowCtrlUnit_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Counts rising edges, so latency can be measured in cycles
	always @(posedge clk)
		cycleCnt <= cycleCnt + 1;

	// ========================================
	// Stimulus helpers and reference model
	// ========================================

	function automatic logic [63:0] xorshift(input logic [63:0] s);
		logic [63:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		return x;
	endfunction

	function automatic word_t nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// Packs the micro-op fields at the positions the configuration header defines
	function automatic instr_t makeInstr(input opcode_t op, input cond_t c, input regNum_t rd,
		input logic [11:0] dw);
		instr_t w;
		w = '0;
		w[`QW_OPC_MSB:`QW_OPC_LSB] = op;
		w[`QW_RD_LSB +: 5] = rd;
		w[`QW_COND_LSB +: 3] = c;
		w[`QW_DISP_LSB +: 12] = dw;
		return w;
	endfunction

	// Compare width of a conditional branch, zero for anything else
	function automatic int branchBits(input opcode_t op);
		case (op)
		OP_BCC8, OP_BCCU8:
			return 8;
		OP_BCC16, OP_BCCU16:
			return 16;
		OP_BCC32, OP_BCCU32:
			return 32;
		OP_BCC64, OP_BCCU64:
			return 64;
		default:
			return 0;
		endcase
	endfunction

	function automatic expect_t modelResult(input opcode_t op, input cond_t c, input regNum_t rd,
		input logic [11:0] dw, input addr_t pcV, input word_t a, input word_t b);
		expect_t e;
		int bits;
		logic sgn;
		word_t dispB;
		word_t mask;
		word_t flip;
		word_t am;
		word_t bm;
		logic eq;
		logic lt;
		e = '0;
		bits = branchBits(op);
		sgn = op inside {OP_BCC8, OP_BCC16, OP_BCC32, OP_BCC64};
		// Displacement counts words, so the byte offset is four times the signed field
		dispB = word_t'(longint'($signed(dw)) * 4);
		e.flowCtrl = (bits != 0) || (op inside {OP_BRK, OP_CHK, OP_BSR, OP_JSR, OP_JSRN});
		if (bits != 0)
		begin
			mask = (bits == 64) ? ~64'd0 : ((64'd1 << bits) - 64'd1);
			// Flipping the top bit of the width turns a signed compare into an unsigned one
			flip = sgn ? (64'd1 << (bits - 1)) : 64'd0;
			am = (a & mask) ^ flip;
			bm = (b & mask) ^ flip;
			eq = (am == bm);
			lt = (am < bm);
			e.isBranch = 1'b1;
			e.redirect = (c == COND_EQ && eq) || (c == COND_NE && !eq) || (c == COND_LT && lt)
				|| (c == COND_GE && !lt) || (c == COND_LE && (lt || eq))
				|| (c == COND_GT && !lt && !eq);
			e.target = pcV + dispB;
		end
		else if (op == OP_BSR || op == OP_JSR || op == OP_JSRN)
		begin
			e.redirect = 1'b1;
			e.target = ((op == OP_BSR) ? pcV : a) + dispB;
			e.linkWe = (op != OP_JSRN);
			e.linkReg = rd;
			e.linkData = pcV + 64'd4;
		end
		else if (op == OP_BRK)
		begin
			e.redirect = 1'b1;
			e.target = `QW_BRK_VECTOR;
			e.fault = FAULT_BRK;
		end
		else if (op == OP_CHK && !(a < b))
		begin
			e.redirect = 1'b1;
			e.target = `QW_CHK_VECTOR;
			e.fault = FAULT_CHK;
		end
		return e;
	endfunction

	task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
		checkCount++;
		assert (got === exp)
		else
		begin
			errCount++;
			$display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic sendOp(input opcode_t op, input cond_t c, input regNum_t rd,
		input logic [11:0] dw, input addr_t pcV, input word_t a, input word_t b);
		expect_t e;
		e = modelResult(op, c, rd, dw, pcV, a, b);
		@(posedge clk);
		// inValid rises on this edge, number cycleCnt+1, and outValid follows three edges later
		e.sendEdge = cycleCnt + 1;
		inValid <= 1'b1;
		instr <= makeInstr(op, c, rd, dw);
		pc <= pcV;
		srcA <= a;
		srcB <= b;
		expQ.push_back(e);
		if (e.isBranch)
			modelBranches = modelBranches + 16'd1;
		if (e.redirect)
			modelTaken = modelTaken + 16'd1;
	endtask

	// Random link register, displacement and word-aligned pc around the given operands
	task automatic sendOperands(input opcode_t op, input cond_t c, input word_t a, input word_t b);
		sendOp(op, c, regNum_t'(nextRand()), 12'(nextRand()), nextRand() & ~64'h3, a, b);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(posedge clk);
		inValid <= 1'b0;
		while (expQ.size() != 0 && waited < 8)
		begin
			@(posedge clk);
			waited++;
		end
		if (expQ.size() != 0)
		begin
			errCount++;
			$display("Result missing: %0d micro-ops never produced outValid", expQ.size());
			expQ.delete();
		end
	endtask

	task automatic checkCounters();
		checkEq(64'(branchCount), 64'(modelBranches), "branchCount");
		checkEq(64'(takenCount), 64'(modelTaken), "takenCount");
	endtask

	task automatic finishTest(input string name, input int startErr);
		$display("Test %s finished with %0d errors", name, errCount - startErr);
	endtask

	// Results are sampled on the falling edge, half a cycle after the port register
	always @(negedge clk)
	begin
		if (arstN && outValid)
		begin
			if (expQ.size() == 0)
			begin
				errCount++;
				$display("Unexpected result at %0t: outValid with no micro-op in flight", $time);
			end
			else
			begin
				cur = expQ.pop_front();
				checkEq(64'(cycleCnt - cur.sendEdge), 64'd3, "latency in cycles");
				checkEq(64'(outFlowCtrl), 64'(cur.flowCtrl), "outFlowCtrl");
				checkEq(64'(redirect), 64'(cur.redirect), "redirect");
				checkEq(64'(linkWe), 64'(cur.linkWe), "linkWe");
				checkEq(64'(fault), 64'(cur.fault), "fault");
				if (cur.redirect)
					checkEq(redirectPc, cur.target, "redirectPc");
				if (cur.linkWe)
				begin
					checkEq(64'(linkReg), 64'(cur.linkReg), "linkReg");
					checkEq(linkData, cur.linkData, "linkData");
				end
			end
		end
	end

	// ========================================
	// Directed tests
	// ========================================

	task automatic testClassify();
		int startErr;
		startErr = errCount;
		foreach (allOps[i])
			sendOperands(allOps[i], cond_t'(nextRand() % 6), nextRand(), nextRand());
		drain();
		finishTest("classification", startErr);
	endtask

	task automatic testBranches();
		int startErr;
		word_t a;
		word_t edgeVal;
		startErr = errCount;
		foreach (bccOps[w])
		begin
			// Only the top bit of the compare width is set
			edgeVal = 64'd1 << ((8 << (w % 4)) - 1);
			for (int c = 0; c < 6; c++)
			begin
				a = nextRand();
				sendOperands(bccOps[w], cond_t'(c), a, a);
				// Differs only above bit 31, so narrow compares see equal operands
				sendOperands(bccOps[w], cond_t'(c), a, a ^ (nextRand() << 32));
				sendOperands(bccOps[w], cond_t'(c), nextRand(), nextRand());
				sendOperands(bccOps[w], cond_t'(c), edgeVal, 64'd1);
			end
		end
		drain();
		finishTest("conditional branches", startErr);
	endtask

	task automatic testCalls();
		int startErr;
		startErr = errCount;
		for (int i = 0; i < 8; i++)
		begin
			sendOperands(OP_BSR, COND_EQ, nextRand(), nextRand());
			sendOperands(OP_JSR, COND_EQ, nextRand(), nextRand());
			sendOperands(OP_JSRN, COND_EQ, nextRand(), nextRand());
		end
		drain();
		finishTest("calls and jumps", startErr);
	endtask

	task automatic testBreakCheck();
		int startErr;
		word_t a;
		startErr = errCount;
		for (int i = 0; i < 4; i++)
			sendOperands(OP_BRK, COND_EQ, nextRand(), nextRand());
		for (int i = 0; i < 4; i++)
		begin
			a = nextRand() >> 1;
			sendOperands(OP_CHK, COND_EQ, a, a + 64'd1 + (nextRand() & 64'hFF));
			sendOperands(OP_CHK, COND_EQ, a, a);
			// With the top bit set the index looks negative, yet it is above the bound
			sendOperands(OP_CHK, COND_EQ, a | (64'd1 << 63), a);
		end
		drain();
		finishTest("break and check", startErr);
	endtask

	task automatic testCountersReset();
		int startErr;
		startErr = errCount;
		for (int i = 0; i < 40; i++)
			sendOperands(allOps[int'(nextRand() % 15)], cond_t'(nextRand() % 6), nextRand(),
				nextRand());
		drain();
		@(negedge clk);
		checkCounters();
		// A break, a call and a taken branch, so every cleared output had something to clear
		sendOperands(OP_BRK, COND_EQ, nextRand(), nextRand());
		sendOperands(OP_BSR, COND_EQ, nextRand(), nextRand());
		sendOperands(OP_BCC8, COND_NE, 64'd1, 64'd2);
		// Reset arrives with three micro-ops still in the pipeline
		@(posedge clk);
		arstN <= 1'b0;
		inValid <= 1'b0;
		expQ.delete();
		modelBranches = '0;
		modelTaken = '0;
		// Without the reset one of the three would commit in each of these cycles
		for (int i = 0; i < 3; i++)
		begin
			@(negedge clk);
			checkEq(64'(outValid), 64'd0, "outValid in reset");
			checkEq(64'(outFlowCtrl), 64'd0, "outFlowCtrl in reset");
			checkEq(64'(redirect), 64'd0, "redirect in reset");
			checkEq(64'(linkWe), 64'd0, "linkWe in reset");
			checkEq(64'(fault), 64'(FAULT_NONE), "fault in reset");
			checkCounters();
		end
		repeat (4) @(posedge clk);
		arstN <= 1'b1;
		for (int i = 0; i < 7; i++)
			sendOperands(allOps[int'(nextRand() % 15)], cond_t'(nextRand() % 6), nextRand(),
				nextRand());
		drain();
		@(negedge clk);
		checkCounters();
		finishTest("counters and reset", startErr);
	endtask

	initial
	begin
		arstN = 1'b0;
		inValid = 1'b0;
		instr = '0;
		pc = '0;
		srcA = '0;
		srcB = '0;
		repeat (4) @(posedge clk);
		arstN <= 1'b1;
		testClassify();
		testBranches();
		testCalls();
		testBreakCheck();
		testCountersReset();
		$display("Summary: %0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog sized from the micro-op count plus room for drains and resets
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+.
Qupls4Pkg.sv
flowIfc.sv
microOpDecode.sv
branchExecute.sv
flowCommit.sv
flowCtrlUnit.sv
flowCtrlUnitTb.sv

/* Makefile */
# Verilator build and run of the flow-control unit testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := flowCtrlUnitTb
FILELIST := build.f
PASS_MSG := All checks passed
BIN      := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# The run passes only when the pass message appears as a line of its own
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
